/* ex_pkg.sv */
`default_nettype none

package ex_pkg;

	localparam int word_w     = 32;
	localparam int reg_addr_w = 5;

	typedef logic [word_w-1:0]   word_t;
	typedef logic [2*word_w-1:0] dword_t;

	// Decoder ALU op codes
	typedef enum logic [7:0] {
		alu_nop   = 8'b0000_0000,
		alu_and   = 8'b0010_0100,
		alu_or    = 8'b0010_0101,
		alu_xor   = 8'b0010_0110,
		alu_nor   = 8'b0010_0111,
		alu_sll   = 8'b0111_1100,
		alu_srl   = 8'b0000_0010,
		alu_sra   = 8'b0000_0011,
		alu_movz  = 8'b0000_1010,
		alu_movn  = 8'b0000_1011,
		alu_mfhi  = 8'b0001_0000,
		alu_mthi  = 8'b0001_0001,
		alu_mflo  = 8'b0001_0010,
		alu_mtlo  = 8'b0001_0011,
		alu_slt   = 8'b0010_1010,
		alu_sltu  = 8'b0010_1011,
		alu_add   = 8'b0010_0000,
		alu_addu  = 8'b0010_0001,
		alu_sub   = 8'b0010_0010,
		alu_subu  = 8'b0010_0011,
		alu_addi  = 8'b0101_0101,
		alu_addiu = 8'b0101_0110,
		alu_clz   = 8'b1011_0000,
		alu_clo   = 8'b1011_0001,
		alu_mult  = 8'b0001_1000,
		alu_multu = 8'b0001_1001,
		alu_mul   = 8'b1010_1001
	} aluop_e;

	typedef enum logic [2:0] {
		sel_nop   = 3'b000,
		sel_logic = 3'b001,
		sel_shift = 3'b010,
		sel_move  = 3'b011,
		sel_arith = 3'b100,
		sel_mul   = 3'b101
	} alusel_e;

	// One decoded instruction entering execute
	typedef struct packed {
		aluop_e                aluop;
		alusel_e               alusel;
		word_t                 reg1;
		word_t                 reg2;
		logic [reg_addr_w-1:0] wd;
		logic                  wreg;
	} ex_op_t;

	typedef struct packed {
		logic  we;
		word_t hi;
		word_t lo;
	} hilo_wr_t;

	typedef struct packed {
		logic [reg_addr_w-1:0] wd;
		logic                  wreg;
		word_t                 wdata;
	} gpr_wr_t;

endpackage

`default_nettype wire

/* ex_logic_shift.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_logic_shift (
	input  ex_pkg::ex_op_t op_i,
	output ex_pkg::word_t  result_o
);
	import ex_pkg::*;

	word_t      a;
	word_t      b;
	logic [4:0] shamt;

	assign a     = op_i.reg1;
	assign b     = op_i.reg2;
	assign shamt = op_i.reg1[4:0]; // Shift amount sits in reg1

	always_comb begin
		case (op_i.aluop)
			alu_or: begin
				result_o = a | b;
			end
			alu_and: begin
				result_o = a & b;
			end
			alu_nor: begin
				result_o = ~(a | b);
			end
			alu_xor: begin
				result_o = a ^ b;
			end
			alu_sll: begin
				result_o = b << shamt;
			end
			alu_srl: begin
				result_o = b >> shamt;
			end
			alu_sra: begin
				result_o = word_t'($signed(b) >>> shamt); // Sign fill
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* ex_arith.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_arith (
	input  ex_pkg::ex_op_t op_i,
	output ex_pkg::word_t  result_o,
	output logic           ov_o
);
	import ex_pkg::*;

	word_t      a;
	word_t      b;
	word_t      b_mux;
	word_t      sum;
	logic       sub_op;
	logic       lt_signed;
	logic       lt_unsigned;
	logic [5:0] lead_zeros;
	logic [5:0] lead_ones;

	// Count of zero bits above the highest set bit
	function automatic logic [5:0] count_lead_zeros(input word_t v);
		logic [5:0] n;
		n = 6'(word_w);
		for (int i = 0; i < word_w; i++) begin
			if (v[i]) begin
				n = 6'(word_w - 1 - i); // Highest set bit wins
			end
		end
		return n;
	endfunction

	assign a = op_i.reg1;
	assign b = op_i.reg2;

	assign sub_op = (op_i.aluop == alu_sub) || (op_i.aluop == alu_subu) ||
		(op_i.aluop == alu_slt);

	assign b_mux = sub_op ? (~b + word_t'(1)) : b;
	assign sum   = a + b_mux;

	// Same-sign operands with a flipped result sign
	assign ov_o = (~a[word_w-1] & ~b_mux[word_w-1] & sum[word_w-1]) |
		(a[word_w-1] & b_mux[word_w-1] & ~sum[word_w-1]);

	// Signed compare from the difference
	assign lt_signed = (a[word_w-1] & ~b[word_w-1]) |
		(~(a[word_w-1] ^ b[word_w-1]) & sum[word_w-1]);
	assign lt_unsigned = a < b;

	assign lead_zeros = count_lead_zeros(a);
	assign lead_ones  = count_lead_zeros(~a);

	always_comb begin
		case (op_i.aluop)
			alu_add, alu_addu, alu_addi, alu_addiu, alu_sub, alu_subu: begin
				result_o = sum;
			end
			alu_slt: begin
				result_o = {{(word_w-1){1'b0}}, lt_signed};
			end
			alu_sltu: begin
				result_o = {{(word_w-1){1'b0}}, lt_unsigned};
			end
			alu_clz: begin
				result_o = {{(word_w-6){1'b0}}, lead_zeros};
			end
			alu_clo: begin
				result_o = {{(word_w-6){1'b0}}, lead_ones};
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* ex_mult.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_mult (
	input  ex_pkg::ex_op_t op_i,
	output ex_pkg::dword_t product_o
);
	import ex_pkg::*;

	logic   signed_op;
	logic   neg_result;
	word_t  mcand;
	word_t  mplier;
	dword_t magnitude;

	assign signed_op = (op_i.aluop == alu_mul) || (op_i.aluop == alu_mult);

	// Magnitudes of the operands for signed ops
	assign mcand = (signed_op && op_i.reg1[word_w-1]) ?
		(~op_i.reg1 + word_t'(1)) : op_i.reg1;
	assign mplier = (signed_op && op_i.reg2[word_w-1]) ?
		(~op_i.reg2 + word_t'(1)) : op_i.reg2;

	assign magnitude = dword_t'(mcand) * dword_t'(mplier);

	assign neg_result = signed_op && (op_i.reg1[word_w-1] ^ op_i.reg2[word_w-1]);

	always_comb begin
		if (neg_result) begin
			product_o = ~magnitude + dword_t'(1);
		end else begin
			product_o = magnitude; // Unsigned product
		end
	end

endmodule

`default_nettype wire

/* ex_hilo.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_hilo (
	input  ex_pkg::ex_op_t   op_i,
	input  ex_pkg::word_t    hi_i,
	input  ex_pkg::word_t    lo_i,
	input  ex_pkg::hilo_wr_t mem_hilo_i,
	input  ex_pkg::hilo_wr_t wb_hilo_i,
	input  ex_pkg::dword_t   product_i,
	output ex_pkg::word_t    move_o,
	output ex_pkg::hilo_wr_t hilo_o
);
	import ex_pkg::*;

	word_t hi_fwd;
	word_t lo_fwd;

	// Youngest pending write wins
	always_comb begin
		if (mem_hilo_i.we) begin
			hi_fwd = mem_hilo_i.hi;
			lo_fwd = mem_hilo_i.lo;
		end else if (wb_hilo_i.we) begin
			hi_fwd = wb_hilo_i.hi;
			lo_fwd = wb_hilo_i.lo;
		end else begin
			hi_fwd = hi_i;
			lo_fwd = lo_i;
		end
	end

	always_comb begin
		case (op_i.aluop)
			alu_mfhi: begin
				move_o = hi_fwd;
			end
			alu_mflo: begin
				move_o = lo_fwd;
			end
			alu_movn, alu_movz: begin
				move_o = op_i.reg1; // Condition resolved in decode
			end
			default: begin
				move_o = '0;
			end
		endcase
	end

	always_comb begin
		hilo_o = '0;
		case (op_i.aluop)
			alu_mult, alu_multu: begin
				hilo_o.we = 1'b1;
				hilo_o.hi = product_i[2*word_w-1:word_w];
				hilo_o.lo = product_i[word_w-1:0];
			end
			alu_mthi: begin
				hilo_o.we = 1'b1;
				hilo_o.hi = op_i.reg1;
				hilo_o.lo = lo_fwd;
			end
			alu_mtlo: begin
				hilo_o.we = 1'b1;
				hilo_o.hi = hi_fwd;
				hilo_o.lo = op_i.reg1;
			end
			default: begin
				hilo_o = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
	input  logic             clk_i,
	input  logic             rst_i,
	input  ex_pkg::ex_op_t   op_i,
	input  ex_pkg::word_t    hi_i,
	input  ex_pkg::word_t    lo_i,
	input  ex_pkg::hilo_wr_t mem_hilo_i,
	input  ex_pkg::hilo_wr_t wb_hilo_i,
	output ex_pkg::gpr_wr_t  gpr_o,
	output ex_pkg::hilo_wr_t hilo_o,
	output logic             ov_o
);
	import ex_pkg::*;

	word_t    ls_res;
	word_t    arith_res;
	word_t    move_res;
	word_t    result;
	dword_t   product;
	logic     arith_ov;
	logic     ov_cancel;
	gpr_wr_t  gpr_next;
	hilo_wr_t hilo_next;

	ex_logic_shift u_logic_shift (
		.op_i     (op_i),
		.result_o (ls_res)
	);

	ex_arith u_arith (
		.op_i     (op_i),
		.result_o (arith_res),
		.ov_o     (arith_ov)
	);

	ex_mult u_mult (
		.op_i      (op_i),
		.product_o (product)
	);

	ex_hilo u_hilo (
		.op_i       (op_i),
		.hi_i       (hi_i),
		.lo_i       (lo_i),
		.mem_hilo_i (mem_hilo_i),
		.wb_hilo_i  (wb_hilo_i),
		.product_i  (product),
		.move_o     (move_res),
		.hilo_o     (hilo_next)
	);

	always_comb begin
		case (op_i.alusel)
			sel_logic, sel_shift: result = ls_res;
			sel_move:             result = move_res;
			sel_arith:            result = arith_res;
			sel_mul:              result = product[word_w-1:0]; // MUL keeps low word
			default:              result = '0;
		endcase
	end

	// Only trapping adds and subtracts are cancelled
	assign ov_cancel = arith_ov && ((op_i.aluop == alu_add) ||
		(op_i.aluop == alu_addi) || (op_i.aluop == alu_sub));

	assign gpr_next.wd    = op_i.wd;
	assign gpr_next.wreg  = op_i.wreg && !ov_cancel;
	assign gpr_next.wdata = result;

	// EX/MEM register
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			gpr_o  <= '0;
			hilo_o <= '0;
			ov_o   <= 1'b0;
		end else begin
			gpr_o  <= gpr_next;
			hilo_o <= hilo_next;
			ov_o   <= ov_cancel;
		end
	end

endmodule

`default_nettype wire

/* tb_ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;
	import ex_pkg::*;

	localparam int n_fields = 23;

	logic     clk_i;
	logic     rst_i;
	ex_op_t   op_i;
	word_t    hi_i;
	word_t    lo_i;
	hilo_wr_t mem_hilo_i;
	hilo_wr_t wb_hilo_i;
	gpr_wr_t  gpr_o;
	hilo_wr_t hilo_o;
	logic     ov_o;

	int              cycle_cnt = 0;
	int              fd;
	int              n_tests;
	int              n_read;
	string           line;
	string           test_name;
	logic [8*24-1:0] name_bits;
	// 0 aluop, 1 alusel, 2 reg1, 3 reg2, 4 wd, 5 wreg, 6 hi, 7 lo, 8 rnd,
	// 9-11 mem write, 12-14 wb write, 15-17 exp gpr, 18-20 exp hilo, 21 exp ov
	logic [31:0]     f [0:21];
	gpr_wr_t         exp_gpr;
	hilo_wr_t        exp_hilo;

	ex_stage dut (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.op_i       (op_i),
		.hi_i       (hi_i),
		.lo_i       (lo_i),
		.mem_hilo_i (mem_hilo_i),
		.wb_hilo_i  (wb_hilo_i),
		.gpr_o      (gpr_o),
		.hilo_o     (hilo_o),
		.ov_o       (ov_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "Simulation stopped on error");
	endtask

	// Returns 1 ns after the n-th rising edge from now
	task automatic wait_cycles(input int n);
		int target;
		int guard;
		target = cycle_cnt + n;
		guard = 0;
		while (cycle_cnt < target) begin
			#1;
			guard++;
			if (guard > 150 * n) begin
				stop_with_failure("Timeout while waiting for clock edges");
			end
		end
	endtask

	task automatic check_gpr(input string name, input gpr_wr_t exp, input gpr_wr_t act);
		if (act !== exp) begin
			stop_with_failure($sformatf(
				"[ERROR] %s gpr_o: expected wd=%h wreg=%b wdata=%h, actual wd=%h wreg=%b wdata=%h",
				name, exp.wd, exp.wreg, exp.wdata, act.wd, act.wreg, act.wdata));
		end
	endtask

	task automatic check_hilo(input string name, input hilo_wr_t exp, input hilo_wr_t act);
		if (act !== exp) begin
			stop_with_failure($sformatf(
				"[ERROR] %s hilo_o: expected we=%b hi=%h lo=%h, actual we=%b hi=%h lo=%h",
				name, exp.we, exp.hi, exp.lo, act.we, act.hi, act.lo));
		end
	endtask

	task automatic check_ov(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			stop_with_failure($sformatf("[ERROR] %s ov_o: expected %b, actual %b",
				name, exp, act));
		end
	endtask

	task automatic apply_vector();
		op_i.aluop  = aluop_e'(f[0][7:0]);
		op_i.alusel = alusel_e'(f[1][2:0]);
		op_i.reg1   = f[2];
		op_i.reg2   = f[3];
		op_i.wd     = f[4][reg_addr_w-1:0];
		op_i.wreg   = f[5][0];
		hi_i        = f[6];
		lo_i        = f[7];
		if (f[8][0]) begin
			// Random forwarding data with the enables held low
			mem_hilo_i = '{we: 1'b0, hi: $urandom(), lo: $urandom()};
			wb_hilo_i  = '{we: 1'b0, hi: $urandom(), lo: $urandom()};
		end else begin
			mem_hilo_i = '{we: f[9][0], hi: f[10], lo: f[11]};
			wb_hilo_i  = '{we: f[12][0], hi: f[13], lo: f[14]};
		end
		exp_gpr  = '{wd: f[15][reg_addr_w-1:0], wreg: f[16][0], wdata: f[17]};
		exp_hilo = '{we: f[18][0], hi: f[19], lo: f[20]};
	endtask

	initial begin
		void'($urandom(32'hedc9ae80));
		rst_i      = 1'b1;
		// A MULT that writes both register files is presented during reset
		op_i       = '{aluop: alu_mult, alusel: sel_mul, reg1: 32'hfffffffd,
			reg2: 32'h7, wd: 5'h1f, wreg: 1'b1};
		hi_i       = '0;
		lo_i       = '0;
		mem_hilo_i = '0;
		wb_hilo_i  = '0;
		n_tests    = 0;

		fd = $fopen("ex_tests.txt", "r");
		if (fd == 0) begin
			stop_with_failure("Could not open the vector file ex_tests.txt");
		end

		// EX/MEM register must hold zeros in and right after reset
		wait_cycles(1);
		check_gpr("reset", '0, gpr_o);
		check_hilo("reset", '0, hilo_o);
		check_ov("reset", 1'b0, ov_o);
		// Overflowing ADD up to the last reset edge
		op_i = '{aluop: alu_add, alusel: sel_arith, reg1: 32'h7fffffff,
			reg2: 32'h1, wd: 5'h1f, wreg: 1'b1};
		wait_cycles(15);
		rst_i = 1'b0;
		check_gpr("reset_release", '0, gpr_o);
		check_hilo("reset_release", '0, hilo_o);
		check_ov("reset_release", 1'b0, ov_o);

		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line.getc(0) != "#") begin
				n_read = $sscanf(line,
					"%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					name_bits, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
					f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17],
					f[18], f[19], f[20], f[21]);
				if (n_read != n_fields) begin
					stop_with_failure({"Malformed line in ex_tests.txt: ", line});
				end
				test_name = $sformatf("%0s", name_bits);
				apply_vector();
				wait_cycles(1); // One cycle latency
				check_gpr(test_name, exp_gpr, gpr_o);
				check_hilo(test_name, exp_hilo, hilo_o);
				check_ov(test_name, f[21][0], ov_o);
				n_tests++;
			end
		end
		$fclose(fd);

		if (n_tests == 0) begin
			stop_with_failure("No test vectors were found in ex_tests.txt");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* ex_tests.txt */
# name aluop sel reg1 reg2 wd wreg hi lo rnd mem_we mem_hi mem_lo wb_we wb_hi wb_lo
# then expected gpr_wd gpr_wreg gpr_wdata hilo_we hilo_hi hilo_lo ov, all hex
or_op        25 1 f0f0ff00 0ff00f0f 01 1 0 0 1 0 0 0 0 0 0 01 1 fff0ff0f 0 0 0 0
and_op       24 1 f0f0ff00 0ff00f0f 01 1 0 0 1 0 0 0 0 0 0 01 1 00f00f00 0 0 0 0
nor_op       27 1 f0f0ff00 0ff00f0f 01 1 0 0 1 0 0 0 0 0 0 01 1 000f00f0 0 0 0 0
xor_op       26 1 f0f0ff00 0ff00f0f 01 1 0 0 1 0 0 0 0 0 0 01 1 ff00f00f 0 0 0 0
sll_op       7c 2 4 8000000f 02 1 0 0 1 0 0 0 0 0 0 02 1 000000f0 0 0 0 0
sll_low5     7c 2 21 3 02 1 0 0 1 0 0 0 0 0 0 02 1 6 0 0 0 0
srl_op       02 2 8 80000f00 02 1 0 0 1 0 0 0 0 0 0 02 1 0080000f 0 0 0 0
sra_neg      03 2 4 f0000080 02 1 0 0 1 0 0 0 0 0 0 02 1 ff000008 0 0 0 0
addu_wrap    21 4 ffffffff 2 04 1 0 0 1 0 0 0 0 0 0 04 1 1 0 0 0 0
subu_wrap    23 4 1 3 04 1 0 0 1 0 0 0 0 0 0 04 1 fffffffe 0 0 0 0
add_ovf      20 4 7fffffff 1 05 1 0 0 1 0 0 0 0 0 0 05 0 80000000 0 0 0 1
addu_noovf   21 4 7fffffff 1 05 1 0 0 1 0 0 0 0 0 0 05 1 80000000 0 0 0 0
add_ok       20 4 5 fffffffd 05 1 0 0 1 0 0 0 0 0 0 05 1 2 0 0 0 0
addi_ovf     55 4 80000000 ffffffff 06 1 0 0 1 0 0 0 0 0 0 06 0 7fffffff 0 0 0 1
addiu_op     56 4 10 20 06 1 0 0 1 0 0 0 0 0 0 06 1 30 0 0 0 0
sub_ovf      22 4 80000000 1 07 1 0 0 1 0 0 0 0 0 0 07 0 7fffffff 0 0 0 1
sub_ok       22 4 9 4 07 1 0 0 1 0 0 0 0 0 0 07 1 5 0 0 0 0
slt_neg_pos  2a 4 ffffffff 1 04 1 0 0 1 0 0 0 0 0 0 04 1 1 0 0 0 0
sltu_neg_pos 2b 4 ffffffff 1 04 1 0 0 1 0 0 0 0 0 0 04 1 0 0 0 0 0
slt_pos_neg  2a 4 1 ffffffff 04 1 0 0 1 0 0 0 0 0 0 04 1 0 0 0 0 0
sltu_pos_neg 2b 4 1 ffffffff 04 1 0 0 1 0 0 0 0 0 0 04 1 1 0 0 0 0
clz_zero     b0 4 0 0 0b 1 0 0 1 0 0 0 0 0 0 0b 1 20 0 0 0 0
clz_bit16    b0 4 00010000 0 0b 1 0 0 1 0 0 0 0 0 0 0b 1 f 0 0 0 0
clo_ones     b1 4 ffffffff 0 0b 1 0 0 1 0 0 0 0 0 0 0b 1 20 0 0 0 0
clo_top4     b1 4 f0000000 0 0b 1 0 0 1 0 0 0 0 0 0 0b 1 4 0 0 0 0
mult_neg     18 0 fffffffd 7 00 0 0 0 1 0 0 0 0 0 0 00 0 0 1 ffffffff ffffffeb 0
multu_neg    19 0 fffffffd 7 00 0 0 0 1 0 0 0 0 0 0 00 0 0 1 6 ffffffeb 0
mult_two_neg 18 0 ffffffff ffffffff 00 0 0 0 1 0 0 0 0 0 0 00 0 0 1 0 1 0
mul_low      a9 5 fffffffd 7 08 1 0 0 1 0 0 0 0 0 0 08 1 ffffffeb 0 0 0 0
mfhi_mem     10 3 0 0 03 1 aaaa bbbb 0 1 c1 c2 1 d1 d2 03 1 c1 0 0 0 0
mflo_mem     12 3 0 0 03 1 aaaa bbbb 0 1 c1 c2 1 d1 d2 03 1 c2 0 0 0 0
mfhi_wb      10 3 0 0 03 1 aaaa bbbb 0 0 c1 c2 1 d1 d2 03 1 d1 0 0 0 0
mflo_wb      12 3 0 0 03 1 aaaa bbbb 0 0 c1 c2 1 d1 d2 03 1 d2 0 0 0 0
mfhi_commit  10 3 0 0 03 1 aaaa bbbb 1 0 0 0 0 0 0 03 1 aaaa 0 0 0 0
mflo_commit  12 3 0 0 03 1 aaaa bbbb 1 0 0 0 0 0 0 03 1 bbbb 0 0 0 0
mthi_mem     11 0 1234 0 00 0 aaaa bbbb 0 1 c1 c2 1 d1 d2 00 0 0 1 1234 c2 0
mtlo_wb      13 0 5678 0 00 0 aaaa bbbb 0 0 c1 c2 1 d1 d2 00 0 0 1 d1 5678 0
mthi_commit  11 0 1234 0 00 0 aaaa bbbb 1 0 0 0 0 0 0 00 0 0 1 1234 bbbb 0
movn_op      0b 3 abcd 1 09 1 0 0 1 0 0 0 0 0 0 09 1 abcd 0 0 0 0
movz_op      0a 3 9876 0 09 1 0 0 1 0 0 0 0 0 0 09 1 9876 0 0 0 0
nop_op       00 0 1 2 00 0 0 0 1 0 0 0 0 0 0 00 0 0 0 0 0 0
bad_sel      25 7 ff 0 0a 1 0 0 1 0 0 0 0 0 0 0a 1 0 0 0 0 0

/* src.f */
ex_pkg.sv
ex_logic_shift.sv
ex_arith.sv
ex_mult.sv
ex_hilo.sv
ex_stage.sv
tb_ex_stage.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_ex_stage -f src.f > build.log 2>&1 \
	|| { cat build.log; echo "FAIL: build error"; exit 1; }
./obj_dir/Vtb_ex_stage > sim.log 2>&1
cat sim.log
grep -q "^Test completed successfully$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
